// File: rtl/bitfield_pkg.sv
package bitfield_pkg;

  localparam int unsigned XLEN = 32;                     // data word width
  localparam logic [XLEN-1:0] WORD_BYTES = XLEN'(4);     // step to the high word

  // major opcodes in the custom-0 and custom-1 slots
  typedef enum logic [6:0] {
    OPCODE_RMLD = 7'b0001011,
    OPCODE_RMST = 7'b0101011
  } opcode_e;

  typedef enum logic [2:0] {
    RMXR   = 3'b000,  // store zeros
    RMXS   = 3'b001,  // store ones
    RMCS   = 3'b010,  // store shadow register bits
    CASRM  = 3'b100,  // store base from rs1
    CALRM  = 3'b101,  // load base from rs2
    CASLRM = 3'b110   // both bases
  } funct3_e;

  typedef enum logic [1:0] {
    OP_CFG,
    OP_LOAD,
    OP_STORE
  } op_kind_e;

  typedef enum logic [2:0] {
    IDLE,
    CFG,
    RD_LO,
    RD_HI,
    WAIT_COMMIT,
    WR_LO,
    WR_HI,
    RETIRE
  } ctrl_state_e;

endpackage

// File: rtl/barrel_rotator.sv
`timescale 1ns/1ps

module barrel_rotator #(
  parameter int unsigned WIDTH = 64
) (
  input  logic [WIDTH-1:0]         data_in,
  input  logic [$clog2(WIDTH)-1:0] amount,
  input  logic                     left,     // 1 rotates toward the msb
  output logic [WIDTH-1:0]         data_out
);

  localparam int unsigned STAGES = $clog2(WIDTH);

  logic [WIDTH-1:0] stage [STAGES+1];

  assign stage[0] = data_in;

  // stage s rotates by 2**s when amount bit s is set
  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    localparam int unsigned SH = 1 << s;
    logic [WIDTH-1:0] rot_l;
    logic [WIDTH-1:0] rot_r;
    assign rot_l = {stage[s][WIDTH-1-SH:0], stage[s][WIDTH-1:WIDTH-SH]};
    assign rot_r = {stage[s][SH-1:0], stage[s][WIDTH-1:SH]};
    assign stage[s+1] = amount[s] ? (left ? rot_l : rot_r) : stage[s];
  end

  assign data_out = stage[STAGES];

endmodule

// File: rtl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            issue_valid,
  input  logic                            issue_ready,
  input  logic [31:0]                     issue_instr,
  input  logic [bitfield_pkg::XLEN-1:0]   issue_rs1,
  input  logic [bitfield_pkg::XLEN-1:0]   issue_rs2,
  input  logic [ID_WIDTH-1:0]             issue_id,
  input  logic                            commit_valid,
  input  logic                            cfg_write,
  input  logic                            retire,
  output logic                            issue_accept,
  output logic                            start,
  output bitfield_pkg::op_kind_e          op_kind,
  output bitfield_pkg::funct3_e           funct3,
  output logic [4:0]                      bit_idx,
  output logic [5:0]                      field_count,
  output logic [bitfield_pkg::XLEN-1:0]   word_addr,
  output logic [ID_WIDTH-1:0]             id,
  output logic [4:0]                      rd,
  output logic                            committed
);

  logic                          is_ld;
  logic                          is_st;
  logic                          f3_cfg;
  logic                          f3_src;
  logic                          take;
  bitfield_pkg::funct3_e         dec_funct3;
  bitfield_pkg::op_kind_e        dec_kind;
  logic [bitfield_pkg::XLEN-1:0] rs1_q;
  logic [bitfield_pkg::XLEN-1:0] rs2_q;
  logic [bitfield_pkg::XLEN-1:0] ld_base_q;
  logic [bitfield_pkg::XLEN-1:0] st_base_q;
  logic [bitfield_pkg::XLEN-1:0] base;

  assign dec_funct3 = bitfield_pkg::funct3_e'(issue_instr[14:12]);
  assign is_ld  = issue_instr[6:0] == bitfield_pkg::OPCODE_RMLD;
  assign is_st  = issue_instr[6:0] == bitfield_pkg::OPCODE_RMST;
  assign f3_cfg = dec_funct3 inside {bitfield_pkg::CASRM, bitfield_pkg::CALRM,
                                     bitfield_pkg::CASLRM};
  assign f3_src = dec_funct3 inside {bitfield_pkg::RMXR, bitfield_pkg::RMXS,
                                     bitfield_pkg::RMCS};

  assign issue_accept = (is_ld | is_st) & (f3_cfg | f3_src);  // pure decode, no valid needed
  assign take         = issue_valid & issue_ready & issue_accept;

  always_comb begin
    if (f3_cfg) begin
      dec_kind = bitfield_pkg::OP_CFG;      // config under either opcode
    end else if (is_ld) begin
      dec_kind = bitfield_pkg::OP_LOAD;
    end else begin
      dec_kind = bitfield_pkg::OP_STORE;
    end
  end

  // operand capture, held until the next take
  always_ff @(posedge clk_i) begin
    if (take) begin
      op_kind <= dec_kind;
      funct3  <= dec_funct3;
      rs1_q   <= issue_rs1;
      rs2_q   <= issue_rs2;
      id      <= issue_id;
      rd      <= issue_instr[11:7];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start     <= 1'b0;
      committed <= 1'b0;
      ld_base_q <= '0;
      st_base_q <= '0;
    end else begin
      start <= take;                        // operands valid with start
      if (retire) begin
        committed <= 1'b0;
      end else if (commit_valid) begin
        committed <= 1'b1;                  // commit may come with the issue itself
      end
      if (cfg_write) begin
        unique case (funct3)
          bitfield_pkg::CASRM: st_base_q <= rs1_q;
          bitfield_pkg::CALRM: ld_base_q <= rs2_q;
          bitfield_pkg::CASLRM: begin
            st_base_q <= rs1_q;
            ld_base_q <= rs2_q;
          end
          default: ;
        endcase
      end
    end
  end

  assign bit_idx     = rs1_q[4:0];
  assign field_count = {1'b0, rs2_q[4:0]} + 6'd1;  // 1 to 32 bits

  assign base      = (op_kind == bitfield_pkg::OP_LOAD) ? ld_base_q : st_base_q;
  assign word_addr = base + {3'b000, rs1_q[bitfield_pkg::XLEN-1:5], 2'b00};

endmodule

// File: rtl/field_datapath.sv
`timescale 1ns/1ps

module field_datapath (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [4:0]                    bit_idx,
  input  logic [5:0]                    field_count,
  input  bitfield_pkg::funct3_e         funct3,
  input  logic [bitfield_pkg::XLEN-1:0] mem_rdata,
  input  logic                          capture_lo,
  input  logic                          capture_hi,
  input  logic                          wr_hi,
  input  logic                          load_done,
  output logic [bitfield_pkg::XLEN-1:0] field,
  output logic [bitfield_pkg::XLEN-1:0] mem_wdata
);

  localparam int unsigned W = 2 * bitfield_pkg::XLEN;  // two-word window

  logic [W-1:0]                  rbuf_q;
  logic [W-1:0]                  mask;
  logic [W-1:0]                  win_rot;
  logic [W-1:0]                  src;
  logic [W-1:0]                  merged_rot;
  logic [W-1:0]                  merged;
  logic [bitfield_pkg::XLEN-1:0] shadow_q;
  logic [$clog2(W)-1:0]          rot_amt;

  // read buffer, high word lands after the low one
  always_ff @(posedge clk_i) begin
    if (capture_lo) begin
      rbuf_q[bitfield_pkg::XLEN-1:0] <= mem_rdata;
    end
    if (capture_hi) begin
      rbuf_q[W-1:bitfield_pkg::XLEN] <= mem_rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else if (load_done) begin
      shadow_q <= field;                    // last loaded field
    end
  end

  assign mask    = ~({W{1'b1}} << field_count);  // count ones at the bottom
  assign rot_amt = {1'b0, bit_idx};

  barrel_rotator #(
    .WIDTH    (W)
  ) u_extract_rot (
    .data_in  (rbuf_q),
    .amount   (rot_amt),
    .left     (1'b0),
    .data_out (win_rot)
  );

  assign field = win_rot[bitfield_pkg::XLEN-1:0] & mask[bitfield_pkg::XLEN-1:0];

  always_comb begin
    unique case (funct3)
      bitfield_pkg::RMXS: src = {W{1'b1}};
      bitfield_pkg::RMCS: src = {{bitfield_pkg::XLEN{1'b0}}, shadow_q};
      default:            src = '0;         // RMXR clears the field
    endcase
  end

  // the merge happens in the extract frame, then the whole window
  // is rotated back so bits outside the field come out unchanged
  assign merged_rot = (win_rot & ~mask) | (src & mask);

  barrel_rotator #(
    .WIDTH    (W)
  ) u_place_rot (
    .data_in  (merged_rot),
    .amount   (rot_amt),
    .left     (1'b1),
    .data_out (merged)
  );

  assign mem_wdata = wr_hi ? merged[W-1:bitfield_pkg::XLEN]
                           : merged[bitfield_pkg::XLEN-1:0];

endmodule

// File: rtl/bitfield_ctrl.sv
`timescale 1ns/1ps

module bitfield_ctrl #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start,
  input  bitfield_pkg::op_kind_e        op_kind,
  input  logic [bitfield_pkg::XLEN-1:0] word_addr,
  input  logic [ID_WIDTH-1:0]           id,
  input  logic [4:0]                    rd,
  input  logic                          committed,
  input  logic                          mem_ready,
  input  logic                          mem_result_valid,
  input  logic                          result_ready,
  input  logic [bitfield_pkg::XLEN-1:0] field,
  output logic                          issue_ready,
  output logic                          cfg_write,
  output logic                          retire,
  output logic                          capture_lo,
  output logic                          capture_hi,
  output logic                          wr_hi,
  output logic                          load_done,
  output logic                          mem_valid,
  output logic [bitfield_pkg::XLEN-1:0] mem_addr,
  output logic                          mem_we,
  output logic                          result_valid,
  output logic [ID_WIDTH-1:0]           result_id,
  output logic [4:0]                    result_rd,
  output logic                          result_we,
  output logic [bitfield_pkg::XLEN-1:0] result_data
);

  bitfield_pkg::ctrl_state_e state_q;
  bitfield_pkg::ctrl_state_e state_d;
  logic                      req_sent_q;   // request taken, result pending
  logic                      in_mem;
  logic                      is_load;

  assign is_load = op_kind == bitfield_pkg::OP_LOAD;
  assign in_mem  = state_q inside {bitfield_pkg::RD_LO, bitfield_pkg::RD_HI,
                                   bitfield_pkg::WR_LO, bitfield_pkg::WR_HI};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      bitfield_pkg::IDLE: begin
        if (start) begin
          state_d = (op_kind == bitfield_pkg::OP_CFG) ? bitfield_pkg::CFG
                                                      : bitfield_pkg::RD_LO;
        end
      end
      bitfield_pkg::CFG: begin
        if (committed) state_d = bitfield_pkg::RETIRE;
      end
      bitfield_pkg::RD_LO: begin
        if (mem_result_valid) state_d = bitfield_pkg::RD_HI;
      end
      bitfield_pkg::RD_HI: begin
        if (mem_result_valid) state_d = bitfield_pkg::WAIT_COMMIT;
      end
      bitfield_pkg::WAIT_COMMIT: begin
        if (committed) begin
          state_d = is_load ? bitfield_pkg::RETIRE : bitfield_pkg::WR_LO;
        end
      end
      bitfield_pkg::WR_LO: begin
        if (mem_result_valid) state_d = bitfield_pkg::WR_HI;
      end
      bitfield_pkg::WR_HI: begin
        if (mem_result_valid) state_d = bitfield_pkg::RETIRE;
      end
      bitfield_pkg::RETIRE: begin
        if (result_ready) state_d = bitfield_pkg::IDLE;
      end
      default: state_d = bitfield_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= bitfield_pkg::IDLE;
      req_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_result_valid) begin
        req_sent_q <= 1'b0;                 // next request one cycle later
      end else if (mem_valid && mem_ready) begin
        req_sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      result_data <= '0;                    // config and store return zero
    end else if (load_done) begin
      result_data <= field;
    end
  end

  // low during the start cycle, so ready drops right after a take
  assign issue_ready = (state_q == bitfield_pkg::IDLE) && !start;

  assign cfg_write  = (state_q == bitfield_pkg::CFG) && committed;
  assign capture_lo = (state_q == bitfield_pkg::RD_LO) && mem_result_valid;
  assign capture_hi = (state_q == bitfield_pkg::RD_HI) && mem_result_valid;
  assign load_done  = (state_q == bitfield_pkg::WAIT_COMMIT) && committed && is_load;
  assign wr_hi      = state_q == bitfield_pkg::WR_HI;

  assign mem_valid = in_mem && !req_sent_q;
  assign mem_we    = state_q inside {bitfield_pkg::WR_LO, bitfield_pkg::WR_HI};
  assign mem_addr  = (state_q inside {bitfield_pkg::RD_HI, bitfield_pkg::WR_HI})
                     ? word_addr + bitfield_pkg::WORD_BYTES : word_addr;

  assign result_valid = state_q == bitfield_pkg::RETIRE;
  assign retire       = result_valid && result_ready;
  assign result_id    = id;
  assign result_rd    = rd;
  assign result_we    = is_load;

  // the memory side must keep a stalled request as it is
  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_we))
    else $error("mem request changed before mem_ready");

  a_no_stray_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == bitfield_pkg::IDLE |-> !mem_result_valid)
    else $error("mem result arrived while idle");

  a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid && !result_ready |=> result_valid && $stable(result_data)
                                      && $stable(result_id))
    else $error("result dropped before result_ready");

endmodule

// File: rtl/bitfield_coproc.sv
`timescale 1ns/1ps

module bitfield_coproc #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // issue
  input  logic                          issue_valid,
  output logic                          issue_ready,
  input  logic [31:0]                   issue_instr,
  input  logic [bitfield_pkg::XLEN-1:0] issue_rs1,
  input  logic [bitfield_pkg::XLEN-1:0] issue_rs2,
  input  logic [ID_WIDTH-1:0]           issue_id,
  output logic                          issue_accept,
  // commit
  input  logic                          commit_valid,
  // memory request and result
  output logic                          mem_valid,
  input  logic                          mem_ready,
  output logic [bitfield_pkg::XLEN-1:0] mem_addr,
  output logic                          mem_we,
  output logic [bitfield_pkg::XLEN-1:0] mem_wdata,
  input  logic                          mem_result_valid,
  input  logic [bitfield_pkg::XLEN-1:0] mem_rdata,
  // result
  output logic                          result_valid,
  input  logic                          result_ready,
  output logic [ID_WIDTH-1:0]           result_id,
  output logic [4:0]                    result_rd,
  output logic                          result_we,
  output logic [bitfield_pkg::XLEN-1:0] result_data
);

  logic                          start;
  bitfield_pkg::op_kind_e        op_kind;
  bitfield_pkg::funct3_e         funct3;
  logic [4:0]                    bit_idx;
  logic [5:0]                    field_count;
  logic [bitfield_pkg::XLEN-1:0] word_addr;
  logic [ID_WIDTH-1:0]           id;
  logic [4:0]                    rd;
  logic                          committed;
  logic                          cfg_write;
  logic                          retire;
  logic                          capture_lo;
  logic                          capture_hi;
  logic                          wr_hi;
  logic                          load_done;
  logic [bitfield_pkg::XLEN-1:0] field;

  issue_stage #(
    .ID_WIDTH     (ID_WIDTH)
  ) u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_instr  (issue_instr),
    .issue_rs1    (issue_rs1),
    .issue_rs2    (issue_rs2),
    .issue_id     (issue_id),
    .commit_valid (commit_valid),
    .cfg_write    (cfg_write),
    .retire       (retire),
    .issue_accept (issue_accept),
    .start        (start),
    .op_kind      (op_kind),
    .funct3       (funct3),
    .bit_idx      (bit_idx),
    .field_count  (field_count),
    .word_addr    (word_addr),
    .id           (id),
    .rd           (rd),
    .committed    (committed)
  );

  bitfield_ctrl #(
    .ID_WIDTH         (ID_WIDTH)
  ) u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .start            (start),
    .op_kind          (op_kind),
    .word_addr        (word_addr),
    .id               (id),
    .rd               (rd),
    .committed        (committed),
    .mem_ready        (mem_ready),
    .mem_result_valid (mem_result_valid),
    .result_ready     (result_ready),
    .field            (field),
    .issue_ready      (issue_ready),
    .cfg_write        (cfg_write),
    .retire           (retire),
    .capture_lo       (capture_lo),
    .capture_hi       (capture_hi),
    .wr_hi            (wr_hi),
    .load_done        (load_done),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_we           (mem_we),
    .result_valid     (result_valid),
    .result_id        (result_id),
    .result_rd        (result_rd),
    .result_we        (result_we),
    .result_data      (result_data)
  );

  field_datapath u_datapath (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bit_idx     (bit_idx),
    .field_count (field_count),
    .funct3      (funct3),
    .mem_rdata   (mem_rdata),
    .capture_lo  (capture_lo),
    .capture_hi  (capture_hi),
    .wr_hi       (wr_hi),
    .load_done   (load_done),
    .field       (field),
    .mem_wdata   (mem_wdata)
  );

endmodule

// File: sim/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic        clk_i,
  input  int unsigned stall_pct,         // chance of mem_ready low, in percent
  input  logic        mem_valid,
  output logic        mem_ready,
  input  logic [31:0] mem_addr,
  input  logic        mem_we,
  input  logic [31:0] mem_wdata,
  output logic        mem_result_valid,
  output logic [31:0] mem_rdata
);

  logic [31:0] words [256];              // 1 KiB, word index from addr[9:2]
  logic [31:0] rdata_q;
  logic [7:0]  widx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      widx = 8'(i);
      words[i] = {widx ^ 8'h3c, ~widx, widx * 8'd37, {widx[3:0], widx[7:4]} ^ 8'ha5};
    end
  end

  // one request at a time, result one to three cycles after acceptance
  initial begin
    mem_ready        = 1'b0;
    mem_result_valid = 1'b0;
    mem_rdata        = '0;
    forever begin
      @(posedge clk_i);
      #1;
      mem_result_valid = 1'b0;
      mem_ready        = (($urandom % 100) >= stall_pct);
      @(negedge clk_i);
      if (mem_valid && mem_ready) begin
        if (mem_we) begin
          words[mem_addr[9:2]] = mem_wdata;
        end
        rdata_q = words[mem_addr[9:2]];
        @(posedge clk_i);                 // acceptance edge
        #1;
        mem_ready = 1'b0;
        repeat ($urandom % 3) begin
          @(posedge clk_i);
          #1;
        end
        mem_rdata        = rdata_q;
        mem_result_valid = 1'b1;          // cleared at the top of the loop
      end
    end
  end

endmodule

// File: sim/tb_bitfield_coproc.sv
`timescale 1ns/1ps

module tb_bitfield_coproc;

  localparam int unsigned ID_W   = 4;
  localparam int unsigned T2_OPS = 13;
  localparam int unsigned T3_OPS = 17;
  localparam int unsigned T4_OPS = 8;
  localparam int unsigned T5_OPS = 16;
  localparam int unsigned N_OPS  = T2_OPS + T3_OPS + T4_OPS + T5_OPS + 1;

  logic clk_i;
  logic rst_ni;
  logic issue_valid;
  logic issue_ready;
  logic [31:0] issue_instr;
  logic [31:0] issue_rs1;
  logic [31:0] issue_rs2;
  logic [ID_W-1:0] issue_id;
  logic issue_accept;
  logic commit_valid;
  logic mem_valid;
  logic mem_ready;
  logic [31:0] mem_addr;
  logic mem_we;
  logic [31:0] mem_wdata;
  logic mem_result_valid;
  logic [31:0] mem_rdata;
  logic result_valid;
  logic result_ready;
  logic [ID_W-1:0] result_id;
  logic [4:0] result_rd;
  logic result_we;
  logic [31:0] result_data;

  // reference model state and expectations of the op in flight
  logic [31:0] ref_mem [256];
  logic [31:0] ref_shadow;
  logic [31:0] ref_ld_base;
  logic [31:0] ref_st_base;
  logic [31:0] exp_addr;
  logic [31:0] exp_lo;
  logic [31:0] exp_hi;
  logic [31:0] exp_data;
  logic exp_we;
  logic [ID_W-1:0] exp_id;
  logic [4:0] exp_rd;
  logic commit_sent;
  logic bad_on;                          // undecoded instruction on the bus
  logic quiet;                           // no memory or result activity allowed
  int unsigned mem_stall_pct;
  int unsigned res_stall_pct;
  int errors;
  int tests_failed;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  bitfield_coproc #(.ID_WIDTH(ID_W)) dut0 (.*);

  tb_mem_model mem0 (
    .clk_i(clk_i), .stall_pct(mem_stall_pct), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
    .mem_result_valid(mem_result_valid), .mem_rdata(mem_rdata)
  );

  initial begin
    result_ready = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      result_ready = (($urandom % 100) >= res_stall_pct);
    end
  end

  a_reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> issue_ready && !mem_valid && !result_valid)
    else begin
      errors++;
      $display("after reset at %0t the DUT was not idle with issue_ready high", $time);
    end

  a_result_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid && result_ready |-> result_data == exp_data && result_we == exp_we
                                     && result_id == exp_id && result_rd == exp_rd)
    else begin
      errors++;
      $display("mismatch at %0t: result %h id %0d rd %0d we %b, expected %h id %0d rd %0d we %b",
               $time, result_data, result_id, result_rd, result_we, exp_data, exp_id, exp_rd,
               exp_we);
    end

  a_write_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && mem_ready && mem_we |-> (mem_addr == exp_addr && mem_wdata == exp_lo)
                                      || (mem_addr == exp_addr + 32'd4 && mem_wdata == exp_hi))
    else begin
      errors++;
      $display("mismatch at %0t: write %h to %h, expected %h/%h at %h", $time, mem_wdata,
               mem_addr, exp_lo, exp_hi, exp_addr);
    end

  a_read_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_we |-> mem_addr == exp_addr || mem_addr == exp_addr + 32'd4)
    else begin
      errors++;
      $display("mismatch at %0t: read address %h, expected %h", $time, mem_addr, exp_addr);
    end

  a_commit_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_valid && mem_we) || result_valid |-> commit_sent)
    else begin
      errors++;
      $display("a write request or result appeared before commit at %0t", $time);
    end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_we)
                                && $stable(mem_wdata))
    else begin
      errors++;
      $display("a stalled memory request changed at %0t", $time);
    end

  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid && !result_ready |=> result_valid && $stable(result_data)
                                      && $stable(result_id) && $stable(result_rd))
    else begin
      errors++;
      $display("a stalled result changed or dropped at %0t", $time);
    end

  a_bad_decode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bad_on |-> !issue_accept)
    else begin
      errors++;
      $display("undecoded instruction was accepted at %0t", $time);
    end

  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    quiet |-> !mem_valid && !result_valid)
    else begin
      errors++;
      $display("memory request or result without a valid instruction at %0t", $time);
    end

  function automatic logic [31:0] ref_extract(logic [63:0] win, int unsigned idx,
                                              int unsigned cnt);
    logic [31:0] r;
    r = '0;
    for (int unsigned b = 0; b < cnt; b++) begin
      r[b] = win[idx + b];
    end
    return r;
  endfunction

  function automatic logic [63:0] ref_insert(logic [63:0] win, int unsigned idx,
                                             int unsigned cnt, logic [31:0] src);
    logic [63:0] r;
    r = win;
    for (int unsigned b = 0; b < cnt; b++) begin
      r[idx + b] = src[b];
    end
    return r;
  endfunction

  // updates the model, drives one instruction and waits for its result
  task automatic do_op(input logic [2:0] f3, input logic load_op, input logic [31:0] rs1,
                       input logic [31:0] rs2, input int unsigned commit_dly);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [31:0] addr;
    logic [63:0] win;
    int unsigned wi;
    int unsigned idx;
    int unsigned cnt;
    logic        took;
    logic        done;
    opc = load_op ? bitfield_pkg::OPCODE_RMLD : bitfield_pkg::OPCODE_RMST;
    rd = 5'($urandom);
    idx = 32'(rs1[4:0]);
    cnt = 32'(rs2[4:0]) + 32'd1;
    exp_id = ID_W'($urandom);
    exp_rd = rd;
    exp_data = '0;
    exp_we = 1'b0;
    if (f3[2]) begin                         // config
      if (f3 != bitfield_pkg::CALRM) ref_st_base = rs1;
      if (f3 != bitfield_pkg::CASRM) ref_ld_base = rs2;
    end else begin
      addr = (load_op ? ref_ld_base : ref_st_base) + (rs1 >> 5) * 32'd4;
      exp_addr = addr;
      wi = 32'(addr[9:2]);
      win = {ref_mem[wi + 1], ref_mem[wi]};
      if (load_op) begin
        exp_data = ref_extract(win, idx, cnt);
        exp_we = 1'b1;
        ref_shadow = exp_data;
      end else begin
        unique case (f3)
          bitfield_pkg::RMXR: win = ref_insert(win, idx, cnt, 32'h0);
          bitfield_pkg::RMXS: win = ref_insert(win, idx, cnt, 32'hffff_ffff);
          default:            win = ref_insert(win, idx, cnt, ref_shadow);
        endcase
        exp_lo = win[31:0];
        exp_hi = win[63:32];
        ref_mem[wi] = exp_lo;
        ref_mem[wi + 1] = exp_hi;
      end
    end
    issue_instr = {17'($urandom), f3, rd, opc};
    issue_rs1 = rs1;
    issue_rs2 = rs2;
    issue_id = exp_id;
    issue_valid = 1'b1;
    commit_valid = (commit_dly == 0);        // commit together with the issue
    commit_sent = (commit_dly == 0);
    do begin
      @(negedge clk_i);
      took = issue_ready && issue_accept;
      @(posedge clk_i);
      #1;
      commit_valid = 1'b0;
    end while (!took);
    issue_valid = 1'b0;
    if (commit_dly > 0) begin
      repeat (commit_dly - 1) begin
        @(posedge clk_i);
        #1;
      end
      commit_valid = 1'b1;
      commit_sent = 1'b1;
      @(posedge clk_i);
      #1;
      commit_valid = 1'b0;
    end
    do begin
      @(negedge clk_i);
      done = result_valid && result_ready;
      @(posedge clk_i);
      #1;
    end while (!done);
    commit_sent = 1'b0;
  endtask

  task automatic rand_op(input logic [2:0] f3, input logic load_op, input int unsigned dly);
    do_op(f3, load_op, {21'd0, 6'($urandom), 5'($urandom)}, $urandom, dly);
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
      tests_failed++;
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < 256; i++) begin
      assert (mem0.words[i] == ref_mem[i])
      else begin
        errors++;
        $display("mismatch at %0t: memory word %0d is %h, expected %h", $time, i,
                 mem0.words[i], ref_mem[i]);
      end
    end
  endtask

  initial begin
    #(N_OPS * 200 * 10);
    $display("timeout: the run did not finish within %0d cycles", N_OPS * 200);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int e;
    void'($urandom(21329));
    rst_ni = 1'b0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_rs1 = '0;
    issue_rs2 = '0;
    issue_id = '0;
    commit_valid = 1'b0;
    commit_sent = 1'b0;
    bad_on = 1'b0;
    quiet = 1'b0;
    mem_stall_pct = 20;
    res_stall_pct = 20;
    errors = 0;
    tests_failed = 0;
    ref_shadow = '0;
    ref_ld_base = '0;
    ref_st_base = '0;
    exp_addr = '0;
    exp_lo = '0;
    exp_hi = '0;
    exp_data = '0;
    exp_we = 1'b0;
    exp_id = '0;
    exp_rd = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < 256; i++) ref_mem[i] = mem0.words[i];
    repeat (2) @(posedge clk_i);
    #1;
    finish_test(1, "reset state", 0);

    e = errors;
    do_op(bitfield_pkg::CASLRM, 1'b1, {23'd0, 7'($urandom), 2'b00},
          {23'd0, 7'($urandom), 2'b00}, 0);
    do_op(bitfield_pkg::RMXR, 1'b1, {21'd0, 6'd3, 5'd20}, {27'd0, 5'd31}, 0);
    do_op(bitfield_pkg::RMXR, 1'b1, {21'd0, 6'd9, 5'd0}, {27'd0, 5'd31}, 1);
    do_op(bitfield_pkg::RMXR, 1'b1, {21'd0, 6'd17, 5'd31}, {27'd0, 5'd31}, 0);
    do_op(bitfield_pkg::RMXR, 1'b1, {21'd0, 6'd40, 5'd31}, {27'd0, 5'd0}, 2);
    for (int i = 0; i < 8; i++) rand_op(bitfield_pkg::RMXR, 1'b1, $urandom % 3);
    finish_test(2, "config and field loads", e);

    e = errors;
    do_op(bitfield_pkg::CASRM, 1'b0, {23'd0, 7'($urandom), 2'b00}, $urandom, 0);
    for (int i = 0; i < 4; i++) begin
      rand_op(bitfield_pkg::RMXR, 1'b0, $urandom % 3);
      rand_op(bitfield_pkg::RMXS, 1'b0, $urandom % 3);
      rand_op(bitfield_pkg::RMXR, 1'b1, $urandom % 3);  // fresh shadow value
      rand_op(bitfield_pkg::RMCS, 1'b0, $urandom % 3);
    end
    check_memory();
    finish_test(3, "field stores", e);

    e = errors;
    for (int i = 0; i < 4; i++) begin
      rand_op(bitfield_pkg::RMXR, 1'b1, 5 + $urandom % 16);
      rand_op(bitfield_pkg::RMCS, 1'b0, 5 + $urandom % 16);
    end
    finish_test(4, "delayed commit", e);

    e = errors;
    mem_stall_pct = 70;
    res_stall_pct = 75;
    for (int i = 0; i < 4; i++) begin
      rand_op(bitfield_pkg::RMXR, 1'b1, $urandom % 4);
      rand_op(bitfield_pkg::RMXS, 1'b0, $urandom % 4);
      rand_op(bitfield_pkg::RMCS, 1'b0, $urandom % 4);
      rand_op(bitfield_pkg::RMXR, 1'b0, $urandom % 4);
    end
    mem_stall_pct = 20;
    res_stall_pct = 20;
    finish_test(5, "back-pressure", e);

    e = errors;
    quiet = 1'b1;
    bad_on = 1'b1;
    issue_valid = 1'b1;
    issue_instr = {17'd0, 3'b000, 5'd3, 7'b0110011};   // plain ALU opcode
    issue_rs1 = $urandom;
    issue_rs2 = $urandom;
    repeat (2) @(posedge clk_i);
    #1;
    issue_instr = {17'd0, 3'b011, 5'd3, 7'b0001011};   // load opcode, unused funct3
    repeat (2) @(posedge clk_i);
    #1;
    issue_valid = 1'b0;                      // withdrawn by the CPU
    bad_on = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    quiet = 1'b0;
    check_memory();
    finish_test(6, "undecoded instruction", e);

    $display("summary: %0d of 6 tests failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: bitfield_coproc.f
rtl/bitfield_pkg.sv
rtl/barrel_rotator.sv
rtl/issue_stage.sv
rtl/field_datapath.sv
rtl/bitfield_ctrl.sv
rtl/bitfield_coproc.sv
sim/tb_mem_model.sv
sim/tb_bitfield_coproc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bitfield coprocessor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_bitfield_coproc -f bitfield_coproc.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"
